// File: rtl/fetch_consts.svh
// fetch front end widths, reset pc and outstanding request limit
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// datapath widths
`define FETCH_PC_WD            32
`define FETCH_INST_WD          32
`define FETCH_SRAM_DATA_WD     64
`define FETCH_SRAM_ADDR_WD     32

// first pc fetched after reset
`define FETCH_PC_RESETVAL      32'h8000_0000

// requests in flight at once, cancelled ones included
`define FETCH_MAX_OUTSTANDING  2

`endif

// File: rtl/fetch_pkg.sv
// fetch front end types and fetch control state encoding
`include "fetch_consts.svh"

package fetch_pkg;

  // pc and instruction
  typedef logic [`FETCH_PC_WD-1:0]        pc_t;
  typedef logic [`FETCH_INST_WD-1:0]      inst_t;

  // instruction sram side
  typedef logic [`FETCH_SRAM_DATA_WD-1:0] sram_word_t;
  typedef logic [`FETCH_SRAM_ADDR_WD-1:0] sram_addr_t;

  // holds 0 .. FETCH_MAX_OUTSTANDING
  typedef logic [1:0]                     outst_cnt_t;

  // FS_DRAIN waits for cancelled responses
  typedef enum logic [1:0] {
    FS_IDLE,   // out of reset, nothing requested yet
    FS_RUN,    // normal fetch
    FS_DRAIN   // cancelled data_ok still to come
  } fetch_state_t;

endpackage

// File: rtl/fetch_buf_if.sv
// handshake between fetch control and the output buffer / pc queue
`timescale 1ns/100ps

interface fetch_buf_if;

  logic push;       // sram accepted a request, queue its pc
  logic rsp_keep;   // data_ok is live, write buffer
  logic flush;      // branch redirect
  logic buf_valid;  // buffer holds an instruction
  logic buf_taken;  // decode takes it this cycle

  modport ctrl (
    output push,
    output rsp_keep,
    output flush,
    output buf_taken,
    input  buf_valid
  );

  modport buffer (
    input  push,
    input  rsp_keep,
    input  flush,
    input  buf_taken,
    output buf_valid
  );

endinterface

// File: rtl/fetch_ctrl.sv
// fetch control FSM, outstanding and cancel counters, request and allowin logic
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_ctrl (
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_ds_allowin,
  input  logic      i_br_taken,
  input  logic      i_addr_ok,
  input  logic      i_data_ok,
  output logic      o_ren,
  output logic      o_pc_advance,
  output logic      o_fs_to_ds_valid,
  fetch_buf_if.ctrl fbuf
);

  localparam fetch_pkg::outst_cnt_t MAX_OUTST = 2'(`FETCH_MAX_OUTSTANDING);

  fetch_pkg::fetch_state_t state_q;
  fetch_pkg::fetch_state_t state_d;
  fetch_pkg::outst_cnt_t   outst_q;   // accepted, data not yet back
  fetch_pkg::outst_cnt_t   outst_d;
  fetch_pkg::outst_cnt_t   cancel_q;  // part of outst_q to be dropped
  fetch_pkg::outst_cnt_t   cancel_d;
  fetch_pkg::outst_cnt_t   live_cnt;
  logic                    req_accept;
  logic                    draining;
  logic                    slot_free;

  // decode side, the buffer is the fetch stage register
  assign o_fs_to_ds_valid = fbuf.buf_valid;
  assign fbuf.buf_taken   = fbuf.buf_valid && i_ds_allowin;

  assign live_cnt = outst_q - cancel_q;
  assign draining = (state_q == fetch_pkg::FS_DRAIN);

  // data_ok is a pulse and cannot be stalled, so the one buffer entry
  // must be free for every live request; one live request at most
  assign slot_free = (live_cnt == '0) && (!fbuf.buf_valid || fbuf.buf_taken);

  assign o_ren = (state_q != fetch_pkg::FS_IDLE) && (outst_q < MAX_OUTST) && slot_free;

  assign req_accept   = o_ren && i_addr_ok;
  assign o_pc_advance = req_accept;

  // accepted in the branch cycle means cancelled, keep it out of the pc queue
  assign fbuf.push     = req_accept && !i_br_taken;
  assign fbuf.rsp_keep = i_data_ok && !draining && !i_br_taken;
  assign fbuf.flush    = i_br_taken;

  always_comb begin
    outst_d = outst_q;
    if (req_accept && !i_data_ok) begin
      outst_d = outst_q + 2'd1;
    end else if (!req_accept && i_data_ok) begin
      outst_d = outst_q - 2'd1;
    end
  end

  // on a branch everything still out after this cycle is dead
  always_comb begin
    cancel_d = cancel_q;
    if (i_br_taken) begin
      cancel_d = outst_d;
    end else if (i_data_ok && draining) begin
      cancel_d = cancel_q - 2'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::FS_IDLE: begin
        state_d = fetch_pkg::FS_RUN;  // start fetching the reset pc
      end
      fetch_pkg::FS_RUN: begin
        if (cancel_d != '0) begin
          state_d = fetch_pkg::FS_DRAIN;
        end
      end
      fetch_pkg::FS_DRAIN: begin
        if (cancel_d == '0) begin
          state_d = fetch_pkg::FS_RUN;
        end
      end
      default: begin
        state_d = fetch_pkg::FS_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q  <= fetch_pkg::FS_IDLE;
      outst_q  <= '0;
      cancel_q <= '0;
    end else begin
      state_q  <= state_d;
      outst_q  <= outst_d;
      cancel_q <= cancel_d;
    end
  end

  // request limit holds across accept / return overlap
  outst_limit_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    outst_q <= MAX_OUTST
  );

  // sram returns data only for accepted requests
  no_orphan_rsp_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_data_ok |-> (outst_q != '0)
  );

endmodule

// File: rtl/pc_gen.sv
// next request pc register with branch redirect and sram address alignment
`timescale 1ns/100ps
`include "fetch_consts.svh"

module pc_gen (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_pc_advance,
  input  logic                  i_br_taken,
  input  fetch_pkg::pc_t        i_br_target,
  output fetch_pkg::pc_t        o_req_pc,
  output fetch_pkg::sram_addr_t o_inst_sram_addr
);

  fetch_pkg::pc_t pc_q;     // pc of the next request
  fetch_pkg::pc_t pc_seq;
  fetch_pkg::pc_t pc_d;

  assign pc_seq = pc_q + fetch_pkg::pc_t'(4);

  // branch wins over a same cycle accept
  always_comb begin
    pc_d = pc_q;
    if (i_br_taken) begin
      pc_d = i_br_target;
    end else if (i_pc_advance) begin
      pc_d = pc_seq;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= `FETCH_PC_RESETVAL;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign o_req_pc = pc_q;

  // sram reads 64 bit words, drop the low 3 bits
  assign o_inst_sram_addr = fetch_pkg::sram_addr_t'({pc_q[`FETCH_PC_WD-1:3], 3'b000});

  // targets from decode must be word aligned too
  pc_aligned_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    pc_q[1:0] == 2'b00
  );

endmodule

// File: rtl/fetch_buf.sv
// in-flight pc queue, 32-bit half select by pc[2] and one-entry output buffer
`timescale 1ns/100ps
`include "fetch_consts.svh"

module fetch_buf (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  fetch_pkg::pc_t        i_req_pc,
  input  fetch_pkg::sram_word_t i_rdata,
  fetch_buf_if.buffer           fbuf,
  output fetch_pkg::inst_t      o_inst,
  output fetch_pkg::pc_t        o_pc
);

  localparam int Q_DEPTH = `FETCH_MAX_OUTSTANDING;
  localparam int QPTR_WD = $clog2(Q_DEPTH);
  localparam fetch_pkg::outst_cnt_t Q_FULL = 2'(Q_DEPTH);

  fetch_pkg::pc_t        pcq_mem [Q_DEPTH];
  logic [QPTR_WD-1:0]    wr_ptr;
  logic [QPTR_WD-1:0]    rd_ptr;
  fetch_pkg::outst_cnt_t pcq_cnt;
  fetch_pkg::pc_t        head_pc;
  fetch_pkg::inst_t      sel_inst;
  logic                  pop;
  logic                  buf_valid_q;
  fetch_pkg::inst_t      buf_inst_q;
  fetch_pkg::pc_t        buf_pc_q;

  assign pop     = fbuf.rsp_keep;  // one live pc per kept response
  assign head_pc = pcq_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (fbuf.push) begin
      pcq_mem[wr_ptr] <= i_req_pc;
    end
  end

  // redirect drops every queued pc
  always_ff @(posedge i_clk) begin
    if (i_reset || fbuf.flush) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      pcq_cnt <= '0;
    end else begin
      if (fbuf.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({fbuf.push, pop})
        2'b10:   pcq_cnt <= pcq_cnt + 2'd1;
        2'b01:   pcq_cnt <= pcq_cnt - 2'd1;
        default: pcq_cnt <= pcq_cnt;
      endcase
    end
  end

  // upper half holds pc+4 of the aligned word
  assign sel_inst = head_pc[2] ? i_rdata[`FETCH_SRAM_DATA_WD-1:`FETCH_INST_WD]
                               : i_rdata[`FETCH_INST_WD-1:0];

  always_ff @(posedge i_clk) begin
    if (i_reset || fbuf.flush) begin
      buf_valid_q <= 1'b0;
    end else if (pop) begin
      buf_valid_q <= 1'b1;
    end else if (fbuf.buf_taken) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (pop) begin
      buf_inst_q <= sel_inst;
      buf_pc_q   <= head_pc;
    end
  end

  assign fbuf.buf_valid = buf_valid_q;
  assign o_inst         = buf_inst_q;
  assign o_pc           = buf_pc_q;

  // control never accepts more live requests than the queue holds
  pcq_no_overflow_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    fbuf.push |-> (pcq_cnt != Q_FULL)
  );

  // every kept response has its pc queued
  pcq_no_underflow_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    pop |-> (pcq_cnt != '0)
  );

  // a kept response finds the entry free or leaving
  buf_no_overwrite_a: assert property (
    @(posedge i_clk) disable iff (i_reset)
    pop |-> (!buf_valid_q || fbuf.buf_taken)
  );

endmodule

// File: rtl/fetch_top.sv
// instruction fetch front end top, control plus pc and buffer datapath
`timescale 1ns/100ps

module fetch_top (
  input  logic                  i_clk,
  input  logic                  i_reset,
  // decode allowin and branch redirect
  input  logic                  i_ds_allowin,
  input  logic                  i_br_taken,
  input  fetch_pkg::pc_t        i_br_target,
  // inst sram
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr,
  input  fetch_pkg::sram_word_t i_inst_sram_rdata,
  input  logic                  i_inst_sram_addr_ok,
  input  logic                  i_inst_sram_data_ok,
  // to decode
  output logic                  o_fs_to_ds_valid,
  output fetch_pkg::inst_t      o_fs_inst,
  output fetch_pkg::pc_t        o_fs_pc
);

  fetch_pkg::pc_t req_pc;
  logic           pc_advance;

  fetch_buf_if fbuf_if ();

  fetch_ctrl ctrl_i (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_allowin     (i_ds_allowin),
    .i_br_taken       (i_br_taken),
    .i_addr_ok        (i_inst_sram_addr_ok),
    .i_data_ok        (i_inst_sram_data_ok),
    .o_ren            (o_inst_sram_ren),
    .o_pc_advance     (pc_advance),        // accepted, move to pc+4
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .fbuf             (fbuf_if.ctrl)
  );

  pc_gen pc_gen_i (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_pc_advance     (pc_advance),
    .i_br_taken       (i_br_taken),
    .i_br_target      (i_br_target),
    .o_req_pc         (req_pc),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  fetch_buf fetch_buf_i (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_req_pc         (req_pc),             // queued on accept
    .i_rdata          (i_inst_sram_rdata),
    .fbuf             (fbuf_if.buffer),
    .o_inst           (o_fs_inst),
    .o_pc             (o_fs_pc)
  );

endmodule

// File: verif/tb_inst_sram.sv
// behavioral instruction sram with random accept and in-order delayed return
`timescale 1ns/100ps

module tb_inst_sram (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic [31:0] i_rnd,      // fresh random bits every cycle
  input  logic        i_ren,
  input  logic [31:0] i_addr,
  output logic        o_addr_ok,
  output logic        o_data_ok,
  output logic [63:0] o_rdata,
  output logic [1:0]  o_pending   // accepted, data not yet returned
);

  logic [31:0] addr_q[$];
  int          due_q[$];          // cycle in which data_ok goes out
  int          now;
  int          last_due;

  // one instruction per 4-byte address
  function automatic logic [31:0] word_half(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  always @(posedge i_clk) begin : serve
    int          due;
    logic [31:0] a;
    if (i_reset) begin
      addr_q.delete();
      due_q.delete();
      now = 0;
      last_due = 0;
      o_addr_ok <= 1'b0;
      o_data_ok <= 1'b0;
      o_rdata   <= '0;
      o_pending <= '0;
    end else begin
      if (i_ren && o_addr_ok) begin
        due = now + 1 + int'(i_rnd[21:20]) % 3;  // 1 to 3 cycles on
        if (due <= last_due) begin
          due = last_due + 1;  // returns stay in order
        end
        addr_q.push_back(i_addr);
        due_q.push_back(due);
        last_due = due;
      end
      o_data_ok <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= now + 1) begin
        a = addr_q.pop_front();
        void'(due_q.pop_front());
        o_data_ok <= 1'b1;
        o_rdata   <= {word_half(a + 32'd4), word_half(a)};  // upper half is pc+4
      end
      o_addr_ok <= i_rnd[16];
      o_pending <= 2'(addr_q.size());
      now = now + 1;
    end
  end

endmodule

// File: verif/tb_fetch_top.sv
// fetch front end testbench with stimulus, reference model, checks, watchdog and summary
`timescale 1ns/100ps
`include "fetch_consts.svh"

module tb_fetch_top;

  localparam int TEST_CYCLES = 5 + 400 + 200 + 600 + 400 + 2000;  // reset and test budgets
  localparam int WATCHDOG_NS = TEST_CYCLES * 8 * 4;

  logic             clk = 1'b0;
  logic             reset = 1'b1;
  logic             ds_allowin = 1'b1;
  logic             br_taken = 1'b0;
  fetch_pkg::pc_t   br_target = `FETCH_PC_RESETVAL;
  logic [31:0]      sram_rnd = '0;
  logic             ren;
  logic [31:0]      sram_addr;
  logic [63:0]      rdata;
  logic             addr_ok;
  logic             data_ok;
  logic [1:0]       pending;
  logic             fs_valid;
  fetch_pkg::inst_t fs_inst;
  fetch_pkg::pc_t   fs_pc;
  logic [31:0]      seed = 32'h861a;
  logic             allow_rand = 1'b0;  // allowin low about 1/3 of cycles
  logic [7:0]       br_rate = 8'd0;     // branch odds per cycle, out of 256
  fetch_pkg::pc_t   exp_pc = `FETCH_PC_RESETVAL;
  logic             held = 1'b0;
  fetch_pkg::pc_t   held_pc;
  fetch_pkg::inst_t held_inst;
  logic             redirected = 1'b0;  // branch seen, target not delivered yet
  int               xfer_cnt;
  int               lo_cnt;
  int               hi_cnt;
  int               br_cnt;
  int               dual_cnt;           // branches with two requests in flight
  int               land_cnt;           // transfers that started a redirected stream
  int               checks;
  int               errors;
  int               xfer_mark;
  int               err_mark;
  int               br_mark;
  int               dual_mark;
  int               land_mark;

  always #4 clk = ~clk;

  fetch_top dut_i (
    .i_clk (clk), .i_reset (reset), .i_ds_allowin (ds_allowin),
    .i_br_taken (br_taken), .i_br_target (br_target),
    .o_inst_sram_ren (ren), .o_inst_sram_addr (sram_addr), .i_inst_sram_rdata (rdata),
    .i_inst_sram_addr_ok (addr_ok), .i_inst_sram_data_ok (data_ok),
    .o_fs_to_ds_valid (fs_valid), .o_fs_inst (fs_inst), .o_fs_pc (fs_pc)
  );

  tb_inst_sram sram_i (
    .i_clk (clk), .i_reset (reset), .i_rnd (sram_rnd), .i_ren (ren), .i_addr (sram_addr),
    .o_addr_ok (addr_ok), .o_data_ok (data_ok), .o_rdata (rdata), .o_pending (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic fetch_pkg::inst_t expect_inst(input fetch_pkg::pc_t pc);
    return (pc * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  task automatic flag_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic fail_check(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic start_test();
    xfer_mark = xfer_cnt;
    err_mark  = errors;
    br_mark   = br_cnt;
    dual_mark = dual_cnt;
    land_mark = land_cnt;
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d transfers, %0d branches, %0d with two in flight, %0d errors",
             num, name, xfer_cnt - xfer_mark, br_cnt - br_mark, dual_cnt - dual_mark,
             errors - err_mark);
  endtask

  task automatic await_transfers(input int n);
    while (xfer_cnt < xfer_mark + n) @(posedge clk);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // decode side and sram randomness, allowin forced low in a branch cycle
  always @(posedge clk) begin : drive_stim
    logic go_branch;
    logic allow;
    seed = lcg_next(seed);
    sram_rnd <= seed;
    seed = lcg_next(seed);
    go_branch = !reset && (br_rate != 8'd0) && (seed[31:24] < br_rate) && !br_taken;
    seed = lcg_next(seed);
    allow = !allow_rand || ((seed[31:16] % 16'd3) != 16'd0);
    seed = lcg_next(seed);
    br_taken   <= go_branch;
    ds_allowin <= allow && !go_branch;
    if (go_branch) begin
      br_target <= 32'h8000_0000 | {16'h0, seed[31:18], 2'b00};  // pc[2] either way
    end
  end

  // reference model and checks, sampled mid cycle
  always @(negedge clk) begin : check_out
    if (!reset) begin
      if (held) begin
        checks = checks + 3;
        assert (fs_valid) else fail_check("o_fs_to_ds_valid dropped while decode held it");
        assert (fs_pc == held_pc) else flag_mismatch("o_fs_pc", fs_pc, held_pc);
        assert (fs_inst == held_inst) else flag_mismatch("o_fs_inst", fs_inst, held_inst);
      end
      if (fs_valid && ds_allowin) begin
        checks = checks + 2;
        assert (fs_pc == exp_pc) else flag_mismatch("o_fs_pc", fs_pc, exp_pc);
        assert (fs_inst == expect_inst(fs_pc))
          else flag_mismatch("o_fs_inst", fs_inst, expect_inst(fs_pc));
        exp_pc = fs_pc + 32'd4;
        xfer_cnt++;
        if (fs_pc[2]) hi_cnt++;
        else lo_cnt++;
        if (redirected) begin
          land_cnt++;
        end
        redirected = 1'b0;
      end
      if (br_taken) begin
        exp_pc = br_target;  // first transfer after the pulse
        redirected = 1'b1;
        br_cnt++;
        if (pending == 2'd2) dual_cnt++;
      end
      held = fs_valid && !ds_allowin && !br_taken;
      held_pc = fs_pc;
      held_inst = fs_inst;
    end
  end

  initial begin : run_tests
    int lo_mark;
    int hi_mark;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checks = checks + 2;
    assert (!fs_valid) else fail_check("o_fs_to_ds_valid high right after reset");
    assert (!ren) else fail_check("o_inst_sram_ren high right after reset");
    @(negedge clk);
    checks = checks + 2;
    assert (ren) else fail_check("no sram request in the first cycle out of reset");
    assert (sram_addr == `FETCH_PC_RESETVAL)
      else flag_mismatch("o_inst_sram_addr", sram_addr, `FETCH_PC_RESETVAL);
    @(posedge clk);
    start_test();
    await_transfers(65);
    finish_test(1, "reset and sequential stream");
    start_test();
    lo_mark = lo_cnt;
    hi_mark = hi_cnt;
    await_transfers(32);
    checks++;
    assert (lo_cnt > lo_mark && hi_cnt > hi_mark)
      else fail_check("only one half of the sram word was ever delivered");
    finish_test(2, "half selection");
    allow_rand <= 1'b1;
    start_test();
    await_transfers(100);
    finish_test(3, "back-pressure");
    br_rate <= 8'd32;
    start_test();
    run_cycles(400);
    checks++;
    assert (land_cnt > land_mark)
      else fail_check("no transfer reached a branch target in the redirect test");
    finish_test(4, "branch redirect");
    br_rate <= 8'd8;
    start_test();
    run_cycles(2000);
    checks++;
    assert (xfer_cnt - xfer_mark >= 300)
      else fail_check("fetch made too little progress, fewer than 300 transfers");
    finish_test(5, "mixed stress");
    $display("summary: 5 tests, %0d transfers, %0d checks, %0d errors", xfer_cnt, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, fetch stopped making progress", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_buf_if.sv
rtl/fetch_ctrl.sv
rtl/pc_gen.sv
rtl/fetch_buf.sv
rtl/fetch_top.sv
verif/tb_inst_sram.sv
verif/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fetch_top -f vlog.f -Mdir obj_dir \
  && ./obj_dir/Vtb_fetch_top > sim.log 2>&1 \
  || { echo "build or simulation error, see sim.log"; exit 1; }

grep -q "^TEST OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
